//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := idu_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/idu_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/idu_macros.svh
`ifndef IDU_MACROS_SVH
`define IDU_MACROS_SVH

// datapath and register file geometry.
`define XLEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5

// rv32i major opcodes, bits 6:0 of the instruction.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

`endif

//--- src/idu_pkg.sv
`include "idu_macros.svh"

package idu_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation requested from the execute stage ALU.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_EQ
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_REG,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    // stage one payload.
    typedef struct packed {
        xlen_t inst;
        xlen_t pc;
    } fetch_t;

    // stage two payload, handed to execute.
    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        logic [2:0] funct3;
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        xlen_t     imm;
        alu_op_e   alu_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        logic      reg_wen;
        logic      mem_wen;
        logic      mem_ren;
        logic      branch;
        logic      branch_inv;
        logic      jump;
    } decoded_t;

endpackage

//--- src/idu_top.sv
`timescale 1ns/1ps

module idu_top
    import idu_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    input  logic       in_valid,
    output logic       in_ready,
    input  xlen_t      in_inst,
    input  xlen_t      in_pc,

    input  logic       flush,

    input  logic       wb_wen,
    input  reg_addr_t  wb_rd,
    input  xlen_t      wb_data,

    output logic       out_valid,
    input  logic       out_ready,
    output xlen_t      out_pc,
    output xlen_t      out_rs1_value,
    output xlen_t      out_rs2_value,
    output xlen_t      out_imm,
    output reg_addr_t  out_rd,
    output logic [2:0] out_funct3,
    output alu_op_e    out_alu_op,
    output op1_sel_e   out_op1_sel,
    output op2_sel_e   out_op2_sel,
    output logic       out_reg_wen,
    output logic       out_mem_wen,
    output logic       out_mem_ren,
    output logic       out_branch,
    output logic       out_branch_inv,
    output logic       out_jump
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    decoded_t  dec_out;

    stage_if fetch_if ();

    inst_capture u_capture (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_inst  (in_inst),
        .in_pc    (in_pc),
        .flush    (flush),
        .fetch    (fetch_if)
    );

    inst_decoder u_decoder (
        .clock     (clock),
        .reset     (reset),
        .fetch     (fetch_if),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (dec_out)
    );

    reg_file u_regs (
        .clock     (clock),
        .reset     (reset),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb_wen    (wb_wen),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // flatten the decoded payload onto the execute-side ports.
    assign out_pc         = dec_out.pc;
    assign out_rs1_value  = dec_out.rs1_value;
    assign out_rs2_value  = dec_out.rs2_value;
    assign out_imm        = dec_out.imm;
    assign out_rd         = dec_out.rd;
    assign out_funct3     = dec_out.funct3;
    assign out_alu_op     = dec_out.alu_op;
    assign out_op1_sel    = dec_out.op1_sel;
    assign out_op2_sel    = dec_out.op2_sel;
    assign out_reg_wen    = dec_out.reg_wen;
    assign out_mem_wen    = dec_out.mem_wen;
    assign out_mem_ren    = dec_out.mem_ren;
    assign out_branch     = dec_out.branch;
    assign out_branch_inv = dec_out.branch_inv;
    assign out_jump       = dec_out.jump;

endmodule

//--- src/inst_capture.sv
`timescale 1ns/1ps

module inst_capture
    import idu_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    input  logic    in_valid,
    output logic    in_ready,
    input  xlen_t   in_inst,
    input  xlen_t   in_pc,

    input  logic    flush,

    stage_if.producer fetch
);

    logic   pending_kill;
    logic   accept;
    logic   kill;
    logic   stage_valid;
    fetch_t stage_in;
    fetch_t stage_out;

    assign accept = in_valid && in_ready;

    // a flush kills the instruction taken now, or else the next one taken.
    assign kill        = flush || pending_kill;
    assign stage_valid = in_valid && !kill;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_kill <= 1'b0;
        end else if (accept) begin
            pending_kill <= 1'b0;
        end else if (flush) begin
            pending_kill <= 1'b1;
        end
    end

    assign stage_in.inst = in_inst;
    assign stage_in.pc   = in_pc;

    pipe_stage #(
        .payload_t (fetch_t)
    ) u_stage (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (stage_valid),
        .in_ready  (in_ready),
        .in_data   (stage_in),
        .out_valid (fetch.valid),
        .out_ready (fetch.ready),
        .out_data  (stage_out)
    );

    assign fetch.inst = stage_out.inst;
    assign fetch.pc   = stage_out.pc;

    kill_cleared_by_accept: assert property (
        @(posedge clock) disable iff (reset)
        accept |=> !pending_kill
    ) else $error("inst_capture: pending kill survived an accept");

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`include "idu_macros.svh"

module inst_decoder
    import idu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    stage_if.consumer fetch,

    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,

    output logic      out_valid,
    input  logic      out_ready,
    output decoded_t  out_data
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b5;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    decoded_t   dec;

    assign opcode = fetch.inst[6:0];
    assign funct3 = fetch.inst[14:12];
    assign f7b5   = fetch.inst[30];

    // operands are read for every format, used or not.
    assign rs1_addr = fetch.inst[19:15];
    assign rs2_addr = fetch.inst[24:20];

    assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
    assign imm_s = {{20{fetch.inst[31]}}, fetch.inst[31:25], fetch.inst[11:7]};
    assign imm_b = {{19{fetch.inst[31]}}, fetch.inst[31], fetch.inst[7],
                    fetch.inst[30:25], fetch.inst[11:8], 1'b0};
    assign imm_u = {fetch.inst[31:12], 12'b0};
    assign imm_j = {{11{fetch.inst[31]}}, fetch.inst[31], fetch.inst[19:12],
                    fetch.inst[20], fetch.inst[30:21], 1'b0};

    // shared by OP and OP-IMM; only OP turns bit 30 into a subtract.
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic b30,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && b30) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = b30 ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec           = '0;
        dec.pc        = fetch.pc;
        dec.rd        = fetch.inst[11:7];
        dec.funct3    = funct3;
        dec.rs1_value = rs1_value;
        dec.rs2_value = rs2_value;
        dec.alu_op    = ALU_ADD;
        dec.op1_sel   = OP1_REG;
        dec.op2_sel   = OP2_REG;

        case (opcode)
            `OPC_LUI: begin
                dec.imm     = imm_u;
                dec.op1_sel = OP1_ZERO;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
            end
            `OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.op1_sel = OP1_PC;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
            end
            `OPC_JAL: begin
                dec.imm     = imm_j;
                dec.op1_sel = OP1_PC;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
                dec.jump    = 1'b1;
            end
            `OPC_JALR: begin
                dec.imm     = imm_i;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
                dec.jump    = 1'b1;
            end
            `OPC_BRANCH: begin
                dec.imm        = imm_b;
                dec.branch     = 1'b1;
                dec.branch_inv = (funct3 == 3'b001) || (funct3 == 3'b101) ||
                                 (funct3 == 3'b111);
                case (funct3[2:1])
                    2'b00:   dec.alu_op = ALU_EQ;
                    2'b10:   dec.alu_op = ALU_SLT;
                    2'b11:   dec.alu_op = ALU_SLTU;
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            `OPC_LOAD: begin
                dec.imm     = imm_i;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
                dec.mem_ren = 1'b1;
            end
            `OPC_STORE: begin
                dec.imm     = imm_s;
                dec.op2_sel = OP2_IMM;
                dec.mem_wen = 1'b1;
            end
            `OPC_OP_IMM: begin
                dec.imm     = imm_i;
                dec.op2_sel = OP2_IMM;
                dec.reg_wen = 1'b1;
                dec.alu_op  = arith_op(funct3, f7b5, 1'b0);
            end
            `OPC_OP: begin
                dec.reg_wen = 1'b1;
                dec.alu_op  = arith_op(funct3, f7b5, 1'b1);
            end
            default: begin
                // unknown opcode leaves the defaults, no side effects.
                dec.imm = '0;
            end
        endcase
    end

    pipe_stage #(
        .payload_t (decoded_t)
    ) u_stage (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (fetch.valid),
        .in_ready  (fetch.ready),
        .in_data   (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

//--- src/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held entry leaves this cycle.
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            data_q <= '0;
        end else if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    held_payload_stable: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe_stage: payload changed while stalled");

    empty_after_reset: assert property (
        @(posedge clock) reset |=> !out_valid
    ) else $error("pipe_stage: out_valid high right after reset");

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "idu_macros.svh"

module reg_file
    import idu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_value,
    output xlen_t     rs2_value,

    input  logic      wb_wen,
    input  reg_addr_t wb_rd,
    input  xlen_t     wb_data
);

    xlen_t regs [0:`NUM_REGS-1];
    logic  wr_en;

    // entry 0 is never written, so x0 stays zero from reset on.
    assign wr_en = wb_wen && (wb_rd != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first: a same-cycle write is seen by the read.
    assign rs1_value = (wr_en && (wb_rd == rs1_addr)) ? wb_data : regs[rs1_addr];
    assign rs2_value = (wr_en && (wb_rd == rs2_addr)) ? wb_data : regs[rs2_addr];

    x0_reads_zero: assert property (
        @(posedge clock) disable iff (reset)
        ((rs1_addr == '0) |-> (rs1_value == '0)) and
        ((rs2_addr == '0) |-> (rs2_value == '0))
    ) else $error("reg_file: x0 read back nonzero");

endmodule

//--- src/stage_if.sv
`timescale 1ns/1ps

interface stage_if
    import idu_pkg::*;
();

    logic  valid;
    logic  ready;
    xlen_t inst;
    xlen_t pc;

    modport producer (
        output valid,
        output inst,
        output pc,
        input  ready
    );

    modport consumer (
        input  valid,
        input  inst,
        input  pc,
        output ready
    );

endinterface

//--- tests/idu_tb.sv
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_tb
    import idu_pkg::*;
();

    // about 300 instructions at up to four cycles each, plus reset and preload.
    localparam int MAX_CYCLES = 1500;
    localparam int N_STREAM   = 40;
    localparam int N_RANDOM   = 220;

    typedef struct packed {
        decoded_t    dec;
        logic [31:0] cycle;
        logic        timed;
    } exp_entry_t;

    logic       clock;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    xlen_t      in_inst;
    xlen_t      in_pc;
    logic       flush;
    logic       wb_wen;
    reg_addr_t  wb_rd;
    xlen_t      wb_data;
    logic       out_valid;
    logic       out_ready;
    xlen_t      out_pc;
    xlen_t      out_rs1_value;
    xlen_t      out_rs2_value;
    xlen_t      out_imm;
    reg_addr_t  out_rd;
    logic [2:0] out_funct3;
    alu_op_e    out_alu_op;
    op1_sel_e   out_op1_sel;
    op2_sel_e   out_op2_sel;
    logic       out_reg_wen;
    logic       out_mem_wen;
    logic       out_mem_ren;
    logic       out_branch;
    logic       out_branch_inv;
    logic       out_jump;

    logic [31:0] lfsr_state = 32'hf279;
    xlen_t       reg_model [0:`NUM_REGS-1];
    exp_entry_t  expected [$];
    logic        kill_next;
    int          cycle;
    int          value_errors;
    int          other_errors;

    idu_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic xlen_t make_inst();
        xlen_t      inst;
        logic [3:0] cls;
        logic       b30;
        logic [2:0] f3;
        inst = take_bits(32);
        cls  = 4'(take_bits(4) % 10);
        b30  = take_bits(1) != 0;
        f3   = inst[14:12];
        case (cls)
            4'd0: begin
                inst[6:0]   = `OPC_OP;
                inst[31:25] = {1'b0, b30 && (f3 == 3'b000 || f3 == 3'b101), 5'b0};
            end
            4'd1: begin
                inst[6:0] = `OPC_OP_IMM;
                if (f3 == 3'b001 || f3 == 3'b101)
                    inst[31:25] = {1'b0, b30 && (f3 == 3'b101), 5'b0};
            end
            4'd2: inst[6:0] = `OPC_LOAD;
            4'd3: inst[6:0] = `OPC_STORE;
            4'd4: begin
                inst[6:0] = `OPC_BRANCH;
                case (take_bits(3) % 6)
                    0:       inst[14:12] = 3'b000;
                    1:       inst[14:12] = 3'b001;
                    2:       inst[14:12] = 3'b100;
                    3:       inst[14:12] = 3'b101;
                    4:       inst[14:12] = 3'b110;
                    default: inst[14:12] = 3'b111;
                endcase
            end
            4'd5: inst[6:0] = `OPC_JAL;
            4'd6: inst[6:0] = `OPC_JALR;
            4'd7: inst[6:0] = `OPC_LUI;
            4'd8: inst[6:0] = `OPC_AUIPC;
            default: begin
                case (take_bits(2))
                    0:       inst[6:0] = 7'b0001111;
                    1:       inst[6:0] = 7'b1110011;
                    2:       inst[6:0] = 7'b0000000;
                    default: inst[6:0] = 7'b1111111;
                endcase
            end
        endcase
        return inst;
    endfunction

    function automatic alu_op_e expected_alu_op(input logic [2:0] f3, input logic b30,
                                                input logic is_op);
        case (f3)
            3'b000:  return (is_op && b30) ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            3'b001:  return ALU_SLL;
            default: return b30 ? ALU_SRA : ALU_SRL;
        endcase
    endfunction

    function automatic decoded_t decode_ref(input xlen_t inst, input xlen_t pc,
                                            input xlen_t regs [0:`NUM_REGS-1]);
        decoded_t   d;
        logic [2:0] f3;
        f3          = inst[14:12];
        d           = '0;
        d.pc        = pc;
        d.rd        = inst[11:7];
        d.funct3    = f3;
        d.rs1_value = regs[inst[19:15]];
        d.rs2_value = regs[inst[24:20]];
        d.alu_op    = ALU_ADD;
        d.op1_sel   = OP1_REG;
        d.op2_sel   = OP2_REG;
        case (inst[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                d.imm     = inst & 32'hffff_f000;
                d.op1_sel = (inst[6:0] == `OPC_LUI) ? OP1_ZERO : OP1_PC;
                d.op2_sel = OP2_IMM;
                d.reg_wen = 1'b1;
            end
            `OPC_JAL, `OPC_JALR: begin
                if (inst[6:0] == `OPC_JAL) begin
                    d.imm = xlen_t'($signed({inst[31], inst[19:12], inst[20],
                                             inst[30:21], 12'b0}) >>> 11);
                    d.op1_sel = OP1_PC;
                end else begin
                    d.imm = xlen_t'($signed(inst) >>> 20);
                end
                d.op2_sel = OP2_IMM;
                d.reg_wen = 1'b1;
                d.jump    = 1'b1;
            end
            `OPC_BRANCH: begin
                d.imm = xlen_t'($signed({inst[31], inst[7], inst[30:25], inst[11:8],
                                         20'b0}) >>> 19);
                d.branch = 1'b1;
                // bne, bge and bgeu are the odd funct3 codes.
                d.branch_inv = f3[0];
                d.alu_op = (f3[2] == 1'b0) ? ALU_EQ : (f3[1] ? ALU_SLTU : ALU_SLT);
            end
            `OPC_LOAD, `OPC_OP_IMM: begin
                d.imm     = xlen_t'($signed(inst) >>> 20);
                d.op2_sel = OP2_IMM;
                d.reg_wen = 1'b1;
                d.mem_ren = (inst[6:0] == `OPC_LOAD);
                if (inst[6:0] == `OPC_OP_IMM)
                    d.alu_op = expected_alu_op(f3, inst[30], 1'b0);
            end
            `OPC_STORE: begin
                d.imm     = xlen_t'($signed({inst[31:25], inst[11:7], 20'b0}) >>> 20);
                d.op2_sel = OP2_IMM;
                d.mem_wen = 1'b1;
            end
            `OPC_OP: begin
                d.reg_wen = 1'b1;
                d.alu_op  = expected_alu_op(f3, inst[30], 1'b1);
            end
            default: begin
            end
        endcase
        return d;
    endfunction

    function automatic decoded_t capture_outputs();
        decoded_t d;
        d.pc         = out_pc;
        d.rd         = out_rd;
        d.funct3     = out_funct3;
        d.rs1_value  = out_rs1_value;
        d.rs2_value  = out_rs2_value;
        d.imm        = out_imm;
        d.alu_op     = out_alu_op;
        d.op1_sel    = out_op1_sel;
        d.op2_sel    = out_op2_sel;
        d.reg_wen    = out_reg_wen;
        d.mem_wen    = out_mem_wen;
        d.mem_ren    = out_mem_ren;
        d.branch     = out_branch;
        d.branch_inv = out_branch_inv;
        d.jump       = out_jump;
        return d;
    endfunction

    task automatic report_value(input string name, input xlen_t exp, input xlen_t act);
        $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
        value_errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("error at cycle %0d: %s", cycle, msg);
        other_errors++;
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            report_value(name, exp, act);
    endtask

    task automatic check_decoded(input decoded_t exp, input decoded_t act);
        check_word("out_pc", exp.pc, act.pc);
        check_word("out_rs1_value", exp.rs1_value, act.rs1_value);
        check_word("out_rs2_value", exp.rs2_value, act.rs2_value);
        check_word("out_imm", exp.imm, act.imm);
        if (act.rd !== exp.rd)
            report_value("out_rd", xlen_t'(exp.rd), xlen_t'(act.rd));
        if (act.funct3 !== exp.funct3)
            report_value("out_funct3", xlen_t'(exp.funct3), xlen_t'(act.funct3));
        if (act.alu_op !== exp.alu_op)
            report_value("out_alu_op", xlen_t'(exp.alu_op), xlen_t'(act.alu_op));
        if (act.op1_sel !== exp.op1_sel)
            report_value("out_op1_sel", xlen_t'(exp.op1_sel), xlen_t'(act.op1_sel));
        if (act.op2_sel !== exp.op2_sel)
            report_value("out_op2_sel", xlen_t'(exp.op2_sel), xlen_t'(act.op2_sel));
        if (act.reg_wen !== exp.reg_wen)
            report_value("out_reg_wen", xlen_t'(exp.reg_wen), xlen_t'(act.reg_wen));
        if (act.mem_wen !== exp.mem_wen)
            report_value("out_mem_wen", xlen_t'(exp.mem_wen), xlen_t'(act.mem_wen));
        if (act.mem_ren !== exp.mem_ren)
            report_value("out_mem_ren", xlen_t'(exp.mem_ren), xlen_t'(act.mem_ren));
        if (act.branch !== exp.branch)
            report_value("out_branch", xlen_t'(exp.branch), xlen_t'(act.branch));
        if (act.branch_inv !== exp.branch_inv)
            report_value("out_branch_inv", xlen_t'(exp.branch_inv), xlen_t'(act.branch_inv));
        if (act.jump !== exp.jump)
            report_value("out_jump", xlen_t'(exp.jump), xlen_t'(act.jump));
    endtask

    // inputs were driven at the falling edge; settle, book the coming edge, then wait.
    task automatic finish_cycle(output logic accepted, input logic timed);
        exp_entry_t e;
        #1.5;
        accepted = in_valid && in_ready;
        if (accepted) begin
            if (!(flush || kill_next)) begin
                e.dec   = decode_ref(in_inst, in_pc, reg_model);
                e.cycle = cycle;
                e.timed = timed;
                expected.push_back(e);
            end
            kill_next = 1'b0;
        end else if (flush) begin
            kill_next = 1'b1;
        end
        @(negedge clock);
    endtask

    // the output side is sampled in the low phase before the next transfer edge.
    initial begin
        decoded_t   act;
        decoded_t   held_data;
        logic       held;
        exp_entry_t e;
        held = 1'b0;
        wait (!reset);
        forever begin
            @(negedge clock);
            #1;
            if (out_valid) begin
                act = capture_outputs();
                if (held && act !== held_data)
                    report_fault("output payload changed while it was held");
                if (out_ready) begin
                    held = 1'b0;
                    if (expected.size() == 0) begin
                        report_fault("output transfer with no instruction expected");
                    end else begin
                        e = expected.pop_front();
                        check_decoded(e.dec, act);
                        if (e.timed && cycle - int'(e.cycle) != 2)
                            report_fault($sformatf("pc 0x%08h took %0d edges, not 2",
                                                   act.pc, cycle - int'(e.cycle)));
                    end
                end else begin
                    held      = 1'b1;
                    held_data = act;
                end
            end else begin
                if (held)
                    report_fault("out_valid dropped before the held output was taken");
                held = 1'b0;
            end
        end
    end

    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clock);
            cycle++;
        end
        $display("timeout after %0d cycles, %0d instructions still expected",
                 cycle, expected.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        logic  acc;
        logic  holding;
        xlen_t pc;
        int    sent;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        in_pc        = '0;
        flush        = 1'b0;
        wb_wen       = 1'b0;
        wb_rd        = '0;
        wb_data      = '0;
        out_ready    = 1'b0;
        kill_next    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        pc           = 32'h0000_1000;
        holding      = 1'b0;
        sent         = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            reg_model[i] = '0;
        end

        repeat (5) @(negedge clock);
        reset = 1'b0;
        finish_cycle(acc, 1'b0);
        if (out_valid !== 1'b0 || in_ready !== 1'b1)
            report_fault("after reset out_valid is not low or in_ready is not high");

        // preload every register, x0 included, while the pipeline is empty.
        for (int i = 0; i < `NUM_REGS; i++) begin
            wb_wen  = 1'b1;
            wb_rd   = reg_addr_t'(i);
            wb_data = take_bits(32);
            if (i != 0)
                reg_model[i] = wb_data;
            finish_cycle(acc, 1'b0);
        end
        wb_wen = 1'b0;

        // back to back with no stalls, so latency is fixed.
        out_ready = 1'b1;
        for (int n = 0; n < N_STREAM; n++) begin
            in_valid = 1'b1;
            in_inst  = make_inst();
            in_pc    = pc;
            pc       = pc + 4;
            finish_cycle(acc, 1'b1);
            if (!acc)
                report_fault("in_ready went low while the output was never stalled");
        end

        // the timed instructions leave before out_ready starts to vary.
        in_valid = 1'b0;
        while (expected.size() != 0) begin
            finish_cycle(acc, 1'b0);
        end

        while (sent < N_RANDOM) begin
            if (!holding) begin
                if (take_bits(2) == 0) begin
                    in_valid = 1'b0;
                end else begin
                    in_valid = 1'b1;
                    in_inst  = make_inst();
                    in_pc    = pc;
                    pc       = pc + 4;
                    holding  = 1'b1;
                end
            end
            out_ready = take_bits(2) != 0;
            flush     = take_bits(4) == 0;
            finish_cycle(acc, 1'b0);
            if (acc && holding) begin
                holding = 1'b0;
                sent++;
            end
        end

        in_valid  = 1'b0;
        flush     = 1'b0;
        out_ready = 1'b1;
        while (expected.size() != 0) begin
            finish_cycle(acc, 1'b0);
        end
        repeat (3) finish_cycle(acc, 1'b0);

        $display("errors: %0d value mismatches, %0d other faults", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
src/idu_pkg.sv
src/stage_if.sv
src/pipe_stage.sv
src/inst_capture.sv
src/inst_decoder.sv
src/reg_file.sv
src/idu_top.sv
tests/idu_tb.sv
